//--- verilog/memDefs_macros.svh
`ifndef MEMDEFS_MACROS_SVH
`define MEMDEFS_MACROS_SVH

// weight memory
`define WEIGHT_BITS     8
`define WEIGHT_DEPTH    256
// output register plus two delay stages
`define WEIGHT_LATENCY  3

// edge memory, halo columns of the image
`define PIXEL_BITS      8
`define KH_MAX          4
// half a kernel height of pixels per word
`define EDGE_BITS       (`PIXEL_BITS * (`KH_MAX / 2))
`define EDGE_DEPTH      64
`define EDGE_LATENCY    1

// lane bank, narrow writes and wide row reads
`define LANE_BITS       4
`define LANE_COUNT      8
`define LANE_ROWS       32
`define LANE_LATENCY    1

`endif

//--- verilog/memPkg.sv
`include "memDefs_macros.svh"

package memPkg;

  // command address, wide enough for the weight memory
  typedef logic [7:0]                                   addr_t;
  typedef logic [`WEIGHT_BITS-1:0]                      weight_t;
  typedef logic [`EDGE_BITS-1:0]                        edge_t;
  typedef logic [`LANE_BITS-1:0]                        lane_t;
  typedef logic [`LANE_BITS*`LANE_COUNT-1:0]            laneRow_t;

  // target select, value 3 is illegal
  typedef logic [1:0] memSel_t;

  localparam memSel_t selWeight = 2'd0;
  localparam memSel_t selEdge   = 2'd1;
  localparam memSel_t selLane   = 2'd2;

  typedef struct packed {
    logic         valid;
    memSel_t      sel;
    logic         write;
    addr_t        addr;
    // narrower memories take the low bits
    logic [15:0]  data;
  } memCmd_t;

  typedef struct packed {
    logic     valid;
    weight_t  data;
  } weightRd_t;

  typedef struct packed {
    logic   valid;
    edge_t  data;
  } edgeRd_t;

  typedef struct packed {
    logic      valid;
    laneRow_t  data;
  } laneRd_t;

endpackage

//--- verilog/pipedSpRam.sv
`timescale 1ns/1ps

module pipedSpRam #(
  parameter int depth   = 256,
  parameter int width   = 8,
  parameter int latency = 3
) (
  input  logic                     clkA,
  input  logic                     en,
  input  logic                     we,
  input  logic [$clog2(depth)-1:0] addr,
  input  logic [width-1:0]         wrData,
  output logic [width-1:0]         rdData
);

  logic [width-1:0] mem [depth];
  // first read stage, the RAM output register
  logic [width-1:0] ramOut;

  // write-first port
  always_ff @(posedge clkA) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wrData;
        // new data shows on the port in the write cycle
        ramOut    <= wrData;
      end else begin
        ramOut    <= mem[addr];
      end
    end
  end

  // remaining latency-1 stages, shifting every cycle
  if (latency > 1) begin : genDelay
    logic [width-1:0] stage [latency-1];

    always_ff @(posedge clkA) begin
      stage[0] <= ramOut;
      for (int i = 1; i < latency - 1; i++) begin
        stage[i] <= stage[i-1];
      end
    end

    assign rdData = stage[latency-2];
  end else begin : genNoDelay
    // single cycle, output register only
    assign rdData = ramOut;
  end

  // out of range address would alias when depth is not a power of two
  addrInRange: assert property (@(posedge clkA) en |-> (addr < depth))
    else $error("pipedSpRam address %0d beyond depth %0d", addr, depth);

endmodule

//--- verilog/laneBankRam.sv
`timescale 1ns/1ps

`include "memDefs_macros.svh"

module laneBankRam
  import memPkg::*;
(
  input  logic                          clkA,
  input  logic                          wrEn,
  input  addr_t                         wrAddr,
  input  lane_t                         wrData,
  input  logic                          rdEn,
  input  logic [$clog2(`LANE_ROWS)-1:0] rdRow,
  output laneRow_t                      rdData
);

  localparam int laneCount   = `LANE_COUNT;
  localparam int laneBits    = `LANE_BITS;
  localparam int laneSelBits = $clog2(`LANE_COUNT);
  localparam int rowBits     = $clog2(`LANE_ROWS);

  logic [laneSelBits-1:0] laneIdx;
  logic [rowBits-1:0]     wrRow;
  // one-hot lane write enable
  logic [laneCount-1:0]   laneWe;

  // low bits pick the lane, the rest pick the row
  assign laneIdx = wrAddr[laneSelBits-1:0];
  assign wrRow   = rowBits'(wrAddr >> laneSelBits);

  always_comb begin
    laneWe          = '0;
    laneWe[laneIdx] = wrEn;
  end

  // one narrow array per lane, all read together
  for (genvar k = 0; k < laneCount; k++) begin : genLane
    lane_t laneMem [`LANE_ROWS];
    lane_t laneQ;

    always_ff @(posedge clkA) begin
      if (laneWe[k]) begin
        laneMem[wrRow] <= wrData;
      end
      if (rdEn) begin
        laneQ <= laneMem[rdRow];
      end
    end

    // lane 0 lands in the lowest bits
    assign rdData[k*laneBits +: laneBits] = laneQ;
  end

  // one command per cycle, so the two ports never collide
  noWrRdSameCycle: assert property (@(posedge clkA) !(wrEn && rdEn))
    else $error("laneBankRam write and read in the same cycle");

endmodule

//--- verilog/memAccessCtrl.sv
`timescale 1ns/1ps

`include "memDefs_macros.svh"

module memAccessCtrl
  import memPkg::*;
(
  input  logic                             clkA,
  input  logic                             rstN,
  input  memCmd_t                          cmd,
  // weight memory port
  output logic                             weightEn,
  output logic                             weightWe,
  output logic [$clog2(`WEIGHT_DEPTH)-1:0] weightAddr,
  output weight_t                          weightWrData,
  // edge memory port
  output logic                             edgeEn,
  output logic                             edgeWe,
  output logic [$clog2(`EDGE_DEPTH)-1:0]   edgeAddr,
  output edge_t                            edgeWrData,
  // lane bank port
  output logic                             laneWrEn,
  output logic                             laneRdEn,
  output logic [$clog2(`LANE_ROWS)-1:0]    laneRdRow,
  output lane_t                            laneWrData,
  // raw read data back from the memories
  input  weight_t                          weightRaw,
  input  edge_t                            edgeRaw,
  input  laneRow_t                         laneRaw,
  output weightRd_t                        weightRd,
  output edgeRd_t                          edgeRd,
  output laneRd_t                          laneRd
);

  localparam int weightAddrBits = $clog2(`WEIGHT_DEPTH);
  localparam int edgeAddrBits   = $clog2(`EDGE_DEPTH);
  localparam int rowBits        = $clog2(`LANE_ROWS);

  logic isWeight;
  logic isEdge;
  logic isLane;

  // one valid bit per stage of each read path
  logic [`WEIGHT_LATENCY-1:0] weightVld;
  logic [`EDGE_LATENCY-1:0]   edgeVld;
  logic [`LANE_LATENCY-1:0]   laneVld;

  // target decode, every valid command is taken
  assign isWeight = cmd.valid && (cmd.sel == selWeight);
  assign isEdge   = cmd.valid && (cmd.sel == selEdge);
  assign isLane   = cmd.valid && (cmd.sel == selLane);

  assign weightEn     = isWeight;
  assign weightWe     = isWeight && cmd.write;
  assign weightAddr   = cmd.addr[weightAddrBits-1:0];
  assign weightWrData = cmd.data[`WEIGHT_BITS-1:0];

  assign edgeEn       = isEdge;
  assign edgeWe       = isEdge && cmd.write;
  assign edgeAddr     = cmd.addr[edgeAddrBits-1:0];
  assign edgeWrData   = cmd.data[`EDGE_BITS-1:0];

  // write address goes to the bank whole, reads carry the row index
  assign laneWrEn     = isLane && cmd.write;
  assign laneRdEn     = isLane && !cmd.write;
  assign laneRdRow    = cmd.addr[rowBits-1:0];
  assign laneWrData   = cmd.data[`LANE_BITS-1:0];

  // read-valid shift registers, stage 0 set at the sampling edge
  always_ff @(posedge clkA) begin
    if (!rstN) begin
      weightVld <= '0;
      edgeVld   <= '0;
      laneVld   <= '0;
    end else begin
      weightVld    <= weightVld << 1;
      weightVld[0] <= weightEn && !weightWe;
      edgeVld      <= edgeVld << 1;
      edgeVld[0]   <= edgeEn && !edgeWe;
      laneVld      <= laneVld << 1;
      laneVld[0]   <= laneRdEn;
    end
  end

  // last stage lines up with the memory output
  assign weightRd.valid = weightVld[`WEIGHT_LATENCY-1];
  assign weightRd.data  = weightRaw;
  assign edgeRd.valid   = edgeVld[`EDGE_LATENCY-1];
  assign edgeRd.data    = edgeRaw;
  assign laneRd.valid   = laneVld[`LANE_LATENCY-1];
  assign laneRd.data    = laneRaw;

  // sel 3 has no target and would be silently dropped
  legalSel: assert property (@(posedge clkA) disable iff (!rstN)
    cmd.valid |-> (cmd.sel != 2'd3))
    else $error("memAccessCtrl illegal memory select");

endmodule

//--- verilog/accelMemTop.sv
`timescale 1ns/1ps

`include "memDefs_macros.svh"

module accelMemTop
  import memPkg::*;
(
  input  logic      clkA,
  input  logic      rstN,
  input  memCmd_t   cmd,
  output weightRd_t weightRd,
  output edgeRd_t   edgeRd,
  output laneRd_t   laneRd
);

  logic                             weightEn;
  logic                             weightWe;
  logic [$clog2(`WEIGHT_DEPTH)-1:0] weightAddr;
  weight_t                          weightWrData;
  weight_t                          weightRaw;

  logic                             edgeEn;
  logic                             edgeWe;
  logic [$clog2(`EDGE_DEPTH)-1:0]   edgeAddr;
  edge_t                            edgeWrData;
  edge_t                            edgeRaw;

  logic                             laneWrEn;
  logic                             laneRdEn;
  logic [$clog2(`LANE_ROWS)-1:0]    laneRdRow;
  lane_t                            laneWrData;
  laneRow_t                         laneRaw;

  memAccessCtrl ctrl (
    .clkA         (clkA),
    .rstN         (rstN),
    .cmd          (cmd),
    .weightEn     (weightEn),
    .weightWe     (weightWe),
    .weightAddr   (weightAddr),
    .weightWrData (weightWrData),
    .edgeEn       (edgeEn),
    .edgeWe       (edgeWe),
    .edgeAddr     (edgeAddr),
    .edgeWrData   (edgeWrData),
    .laneWrEn     (laneWrEn),
    .laneRdEn     (laneRdEn),
    .laneRdRow    (laneRdRow),
    .laneWrData   (laneWrData),
    .weightRaw    (weightRaw),
    .edgeRaw      (edgeRaw),
    .laneRaw      (laneRaw),
    .weightRd     (weightRd),
    .edgeRd       (edgeRd),
    .laneRd       (laneRd)
  );

  // weights, three cycle read
  pipedSpRam #(
    .depth   (`WEIGHT_DEPTH),
    .width   (`WEIGHT_BITS),
    .latency (`WEIGHT_LATENCY)
  ) weightRam (
    .clkA   (clkA),
    .en     (weightEn),
    .we     (weightWe),
    .addr   (weightAddr),
    .wrData (weightWrData),
    .rdData (weightRaw)
  );

  // halo columns, single cycle read
  pipedSpRam #(
    .depth   (`EDGE_DEPTH),
    .width   (`EDGE_BITS),
    .latency (`EDGE_LATENCY)
  ) edgeRam (
    .clkA   (clkA),
    .en     (edgeEn),
    .we     (edgeWe),
    .addr   (edgeAddr),
    .wrData (edgeWrData),
    .rdData (edgeRaw)
  );

  // narrow write address straight from the command
  laneBankRam laneBank (
    .clkA   (clkA),
    .wrEn   (laneWrEn),
    .wrAddr (cmd.addr),
    .wrData (laneWrData),
    .rdEn   (laneRdEn),
    .rdRow  (laneRdRow),
    .rdData (laneRaw)
  );

endmodule

//--- testbench/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
  parameter real halfPeriod  = 4.0,
  parameter int  resetCycles = 3
) (
  output logic clkA,
  output logic rstN
);

  // free-running clock, 8 ns period
  initial begin
    clkA = 1'b0;
    forever #halfPeriod clkA = ~clkA;
  end

  // reset held for the first rising edges, released on a falling edge
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clkA);
    @(negedge clkA);
    rstN = 1'b1;
  end

endmodule

//--- testbench/accelMemTb.sv
`timescale 1ns/1ps

`include "memDefs_macros.svh"

module accelMemTb
  import memPkg::*;
();

  localparam int maxVec = 64;

  // one outstanding read, target plus due cycle and expected value
  typedef struct packed {
    memSel_t       tgt;
    int            due;
    logic [31:0]   value;
    logic [127:0]  name;
  } pending_t;

  logic      clkA;
  logic      rstN;
  memCmd_t   cmd;
  weightRd_t weightRd;
  edgeRd_t   edgeRd;
  laneRd_t   laneRd;

  // vector storage
  logic [7:0]   vecOp   [maxVec];
  logic [31:0]  vecSel  [maxVec];
  logic [31:0]  vecAddr [maxVec];
  logic [31:0]  vecData [maxVec];
  logic [31:0]  vecExp  [maxVec];
  logic [127:0] vecName [maxVec];
  int           vecCount = 0;

  pending_t pendQ [$];
  int       cycleCnt   = 0;
  int       cycleLimit = 0;

  clockGen clkGen (
    .clkA (clkA),
    .rstN (rstN)
  );

  accelMemTop uut (
    .clkA     (clkA),
    .rstN     (rstN),
    .cmd      (cmd),
    .weightRd (weightRd),
    .edgeRd   (edgeRd),
    .laneRd   (laneRd)
  );

  // rising edges since time zero
  always @(posedge clkA) begin
    cycleCnt <= cycleCnt + 1;
  end

  // run limit from the vector count
  always @(posedge clkA) begin
    if (cycleLimit > 0 && cycleCnt >= cycleLimit) begin
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      $display("FAIL: see errors above");
      $fatal(1, "cycle limit reached");
    end
  end

  task failRun(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1, "stopping at first error");
  endtask

  task checkValue(input logic [127:0] testName, input logic [31:0] expected,
                  input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %0s: expected %h, actual %h", testName, expected, actual);
      failRun("read data mismatch");
    end
  endtask

  function int latencyOf(input memSel_t sel);
    if (sel == selWeight) begin
      return `WEIGHT_LATENCY;
    end else if (sel == selEdge) begin
      return `EDGE_LATENCY;
    end else begin
      return `LANE_LATENCY;
    end
  endfunction

  // pair one target's valid with the oldest read pending for it
  task matchResult(input memSel_t tgt, input logic vld, input logic [31:0] data,
                   input logic [127:0] label);
    int idx;
    int i;
    idx = -1;
    for (i = 0; i < pendQ.size(); i++) begin
      if (idx < 0 && pendQ[i].tgt == tgt) begin
        idx = i;
      end
    end
    if (vld && (idx < 0 || pendQ[idx].due != cycleCnt)) begin
      failRun($sformatf("%0s read result at cycle %0d with no read due then",
                        label, cycleCnt));
    end else if (vld) begin
      checkValue(pendQ[idx].name, pendQ[idx].value, data);
      pendQ.delete(idx);
    end else if (idx >= 0 && pendQ[idx].due <= cycleCnt) begin
      failRun($sformatf("%0s read result due at cycle %0d never arrived",
                        label, pendQ[idx].due));
    end
  endtask

  task checkOutputs();
    matchResult(selWeight, weightRd.valid, 32'(weightRd.data), "weight");
    matchResult(selEdge, edgeRd.valid, 32'(edgeRd.data), "edge");
    matchResult(selLane, laneRd.valid, 32'(laneRd.data), "lane");
  endtask

  // due cycle counts from the cycle the command is driven in
  task driveCommand(input int idx);
    pending_t entry;
    cmd = '0;
    if (vecOp[idx] != "i") begin
      cmd.valid = 1'b1;
      cmd.sel   = memSel_t'(vecSel[idx]);
      cmd.write = (vecOp[idx] == "w");
      cmd.addr  = addr_t'(vecAddr[idx]);
      cmd.data  = vecData[idx][15:0];
    end
    if (vecOp[idx] == "r") begin
      entry.tgt   = memSel_t'(vecSel[idx]);
      entry.due   = cycleCnt + latencyOf(memSel_t'(vecSel[idx]));
      entry.value = vecExp[idx];
      entry.name  = vecName[idx];
      pendQ.push_back(entry);
    end
  endtask

  task loadVectors();
    int          fd;
    int          n;
    logic [63:0] opTok;
    logic [1023:0] restOfLine;
    logic [31:0] selVal;
    logic [31:0] addrVal;
    logic [31:0] dataVal;
    logic [31:0] expVal;
    logic [127:0] nameVal;
    fd = $fopen("testbench/accelMem_vectors.txt", "r");
    if (fd == 0) begin
      failRun("cannot open testbench/accelMem_vectors.txt");
    end
    n = $fscanf(fd, "%s", opTok);
    while (n == 1) begin
      if (opTok == "#") begin
        // column notes, skip the rest of the line
        n = $fgets(restOfLine, fd);
      end else if (vecCount >= maxVec) begin
        failRun("vector file has more lines than the testbench can hold");
      end else begin
        n = $fscanf(fd, " %h %h %h %h %s", selVal, addrVal, dataVal, expVal, nameVal);
        if (n != 5) begin
          failRun($sformatf("malformed vector line %0d", vecCount + 1));
        end
        vecOp[vecCount]   = opTok[7:0];
        vecSel[vecCount]  = selVal;
        vecAddr[vecCount] = addrVal;
        vecData[vecCount] = dataVal;
        vecExp[vecCount]  = expVal;
        vecName[vecCount] = nameVal;
        vecCount++;
      end
      n = $fscanf(fd, "%s", opTok);
    end
    $fclose(fd);
  endtask

  initial begin
    cmd = '0;
    loadVectors();
    cycleLimit = 4 * vecCount + 20;

    // all valids low while reset is held
    @(posedge clkA);
    #1;
    while (!rstN) begin
      checkValue("reset", 32'd0, {29'd0, weightRd.valid, edgeRd.valid, laneRd.valid});
      @(posedge clkA);
      #1;
    end

    // one command per cycle, outputs checked just after each edge
    for (int i = 0; i < vecCount; i++) begin
      checkOutputs();
      driveCommand(i);
      @(posedge clkA);
      #1;
    end
    cmd = '0;

    // drain the reads still in flight
    checkOutputs();
    while (pendQ.size() > 0) begin
      @(posedge clkA);
      #1;
      checkOutputs();
    end
    // no stray valids afterwards
    repeat (3) begin
      @(posedge clkA);
      #1;
      checkOutputs();
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- testbench/accelMem_vectors.txt
# op sel addr data expected name, all numbers in hex
# op w write, r read, i idle; sel 0 weight, 1 edge, 2 lane; lane reads give the row
i 0 00 0000 00000000 reset
i 0 00 0000 00000000 reset
i 0 00 0000 00000000 reset
w 0 05 00a5 00000000 weightWr
w 0 06 003c 00000000 weightWr
w 0 ff 0081 00000000 weightWr
w 0 07 0012 00000000 weightWr
r 0 05 0000 000000a5 weightRb
i 0 00 0000 00000000 weightRb
r 0 ff 0000 00000081 weightRb
w 1 03 beef 00000000 edgeWr
w 1 3f 1234 00000000 edgeWr
r 1 3f 0000 00001234 edgeRb
r 1 03 0000 0000beef edgeRb
w 2 10 0003 00000000 lanePack
w 2 11 0007 00000000 lanePack
w 2 12 000a 00000000 lanePack
w 2 13 0000 00000000 lanePack
w 2 14 000f 00000000 lanePack
w 2 15 0005 00000000 lanePack
w 2 16 000c 00000000 lanePack
w 2 17 0009 00000000 lanePack
r 2 02 0000 9c5f0a73 lanePack
w 2 14 0006 00000000 laneOverwrite
r 2 02 0000 9c560a73 laneOverwrite
r 0 05 0000 000000a5 weightPipe
r 0 06 0000 0000003c weightPipe
r 0 07 0000 00000012 weightPipe
r 1 03 0000 0000beef edgeAfterPipe

//--- sim.f
+incdir+verilog
verilog/memPkg.sv
verilog/pipedSpRam.sv
verilog/laneBankRam.sv
verilog/memAccessCtrl.sv
verilog/accelMemTop.sv
testbench/clockGen.sv
testbench/accelMemTb.sv
